// File: lcd_pkg.sv
// bus timing and init list localparams, panel command codes, bus and fill job structs
package lcd_pkg;

    // 8080 bus timing, in pclk cycles
    localparam int unsigned WR_LOW_CYC  = 2;
    localparam int unsigned WR_HIGH_CYC = 2;
    localparam int unsigned RD_LOW_CYC  = 8;   // read word sampled in the last low cycle
    localparam int unsigned RD_HIGH_CYC = 4;
    localparam int unsigned RST_CYC     = 16;  // panel reset pulse, short for simulation

    // init command list
    localparam int unsigned INIT_LEN = 6;
    localparam int unsigned IDX_W    = $clog2(INIT_LEN);
    localparam logic [IDX_W-1:0] INIT_LAST = IDX_W'(INIT_LEN - 1);

    // reset pulse counter
    localparam int unsigned RST_W = $clog2(RST_CYC);
    localparam logic [RST_W-1:0] RST_LAST = RST_W'(RST_CYC - 1);

    // bus interface phase counter
    localparam int unsigned PH_W = 4;
    localparam logic [PH_W-1:0] WR_LOW_END = PH_W'(WR_LOW_CYC);
    localparam logic [PH_W-1:0] WR_LAST    = PH_W'(WR_LOW_CYC + WR_HIGH_CYC - 1);
    localparam logic [PH_W-1:0] RD_LOW_END = PH_W'(RD_LOW_CYC);
    localparam logic [PH_W-1:0] RD_SMP     = PH_W'(RD_LOW_CYC - 1);
    localparam logic [PH_W-1:0] RD_LAST    = PH_W'(RD_LOW_CYC + RD_HIGH_CYC - 1);

    // fill engine phases, 0..10 are window commands and parameters
    localparam int unsigned FILL_PH_W = 4;
    localparam logic [FILL_PH_W-1:0] FILL_PH_PIX = 4'd11;

    // panel commands
    localparam logic [15:0] CMD_CASET = 16'h002A;  // column window
    localparam logic [15:0] CMD_PASET = 16'h002B;  // page window
    localparam logic [15:0] CMD_RAMWR = 16'h002C;  // pixel stream follows

    // one bus operation
    typedef struct packed {
        logic        rd;    // 1: read cycle
        logic        rs;    // 1: data, 0: command
        logic [15:0] data;
    } bus_req_t;

    // one rectangular fill, corners inclusive
    typedef struct packed {
        logic [15:0] x0;
        logic [15:0] y0;
        logic [15:0] x1;
        logic [15:0] y1;
        logic [15:0] color;
    } fill_req_t;

endpackage

// File: lcd_init_seq.sv
// panel reset pulse and init command list sequencer
`timescale 1ns/1ps

module lcd_init_seq (
    input  logic              pclk,
    input  logic              rst_n,
    output logic              req_o,
    output lcd_pkg::bus_req_t req_bus_o,
    input  logic              done_i,
    output logic              lcd_rst_o,
    output logic              init_done_o
);
    import lcd_pkg::*;

    logic [RST_W-1:0] rst_cnt_q;
    logic [IDX_W-1:0] idx_q;

    // reset pulse first, then walk the table one write per done
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            rst_cnt_q   <= '0;
            lcd_rst_o   <= 1'b0;
            idx_q       <= '0;
            init_done_o <= 1'b0;
        end else if (!lcd_rst_o) begin
            if (rst_cnt_q == RST_LAST) begin
                lcd_rst_o <= 1'b1;  // release panel
            end else begin
                rst_cnt_q <= rst_cnt_q + 1'b1;
            end
        end else if (req_o && done_i) begin
            if (idx_q == INIT_LAST) begin
                init_done_o <= 1'b1;  // sticky
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    assign req_o = lcd_rst_o && !init_done_o;

    // init table, rs then word
    always_comb begin
        req_bus_o.rd = 1'b0;
        case (idx_q)
            3'd0:    {req_bus_o.rs, req_bus_o.data} = {1'b0, 16'h0011};  // sleep out
            3'd1:    {req_bus_o.rs, req_bus_o.data} = {1'b0, 16'h003A};  // pixel format
            3'd2:    {req_bus_o.rs, req_bus_o.data} = {1'b1, 16'h0055};  // 16 bpp
            3'd3:    {req_bus_o.rs, req_bus_o.data} = {1'b0, 16'h0036};  // memory access ctrl
            3'd4:    {req_bus_o.rs, req_bus_o.data} = {1'b1, 16'h0000};
            3'd5:    {req_bus_o.rs, req_bus_o.data} = {1'b0, 16'h0029};  // display on
            default: {req_bus_o.rs, req_bus_o.data} = {1'b0, 16'h0000};
        endcase
    end

endmodule

// File: lcd_fill_engine.sv
// rectangular fill engine: window commands then the colour pixel stream
`timescale 1ns/1ps

module lcd_fill_engine (
    input  logic               pclk,
    input  logic               rst_n,
    input  logic               start_i,
    input  lcd_pkg::fill_req_t job_i,
    output logic               req_o,
    output lcd_pkg::bus_req_t  req_bus_o,
    input  logic               done_i,
    output logic               busy_o
);
    import lcd_pkg::*;

    fill_req_t            job_q;
    logic [FILL_PH_W-1:0] phase_q;
    logic [15:0]          col_q;
    logic [15:0]          row_q;
    logic                 take;
    logic                 last_col;
    logic                 last_px;

    assign take     = start_i && !busy_o;
    assign last_col = (col_q == job_q.x1);
    assign last_px  = last_col && (row_q == job_q.y1);

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            busy_o  <= 1'b0;
            phase_q <= '0;
        end else if (take) begin
            busy_o  <= 1'b1;
            phase_q <= '0;
        end else if (busy_o && done_i) begin
            if (phase_q != FILL_PH_PIX) begin
                phase_q <= phase_q + 1'b1;
            end else if (last_px) begin
                busy_o <= 1'b0;  // last pixel written
            end
        end
    end

    // job copy and pixel position, loaded on start
    always_ff @(posedge pclk) begin
        if (take) begin
            job_q <= job_i;
            col_q <= job_i.x0;
            row_q <= job_i.y0;
        end else if (busy_o && done_i && phase_q == FILL_PH_PIX) begin
            if (last_col) begin
                col_q <= job_q.x0;  // wrap to next row
                row_q <= row_q + 16'd1;
            end else begin
                col_q <= col_q + 16'd1;
            end
        end
    end

    assign req_o = busy_o;

    // command or parameter byte for each phase
    always_comb begin
        req_bus_o.rd = 1'b0;
        req_bus_o.rs = 1'b1;
        case (phase_q)
            4'd0:    begin req_bus_o.rs = 1'b0; req_bus_o.data = CMD_CASET; end
            4'd1:    req_bus_o.data = {8'h00, job_q.x0[15:8]};
            4'd2:    req_bus_o.data = {8'h00, job_q.x0[7:0]};
            4'd3:    req_bus_o.data = {8'h00, job_q.x1[15:8]};
            4'd4:    req_bus_o.data = {8'h00, job_q.x1[7:0]};
            4'd5:    begin req_bus_o.rs = 1'b0; req_bus_o.data = CMD_PASET; end
            4'd6:    req_bus_o.data = {8'h00, job_q.y0[15:8]};
            4'd7:    req_bus_o.data = {8'h00, job_q.y0[7:0]};
            4'd8:    req_bus_o.data = {8'h00, job_q.y1[15:8]};
            4'd9:    req_bus_o.data = {8'h00, job_q.y1[7:0]};
            4'd10:   begin req_bus_o.rs = 1'b0; req_bus_o.data = CMD_RAMWR; end
            default: req_bus_o.data = job_q.color;  // pixel phase
        endcase
    end

endmodule

// File: lcd_host_port.sv
// host strobe port: one pending write or read, fill launch, busy and read word
`timescale 1ns/1ps

module lcd_host_port (
    input  logic               pclk,
    input  logic               rst_n,
    input  logic               host_we_i,
    input  logic               host_rs_i,
    input  logic [15:0]        host_data_i,
    input  logic               host_rd_i,
    input  logic               fill_start_i,
    input  lcd_pkg::fill_req_t fill_job_i,
    input  logic               init_done_i,
    input  logic               fill_busy_i,
    output logic               req_o,
    output lcd_pkg::bus_req_t  req_bus_o,
    input  logic               done_i,
    input  logic [15:0]        rd_word_i,
    output logic               fill_go_o,
    output lcd_pkg::fill_req_t fill_job_o,
    output logic               busy_o,
    output logic [15:0]        rd_data_o,
    output logic               rd_valid_o
);
    import lcd_pkg::*;

    logic we_take, rd_take, fill_take;
    logic pend_nxt;

    // strobes only count while idle, write wins over read over fill
    assign we_take   = host_we_i && !busy_o;
    assign rd_take   = host_rd_i && !host_we_i && !busy_o;
    assign fill_take = fill_start_i && !host_we_i && !host_rd_i && !busy_o;

    assign pend_nxt = (we_take || rd_take) ? 1'b1 : (done_i ? 1'b0 : req_o);

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            req_o      <= 1'b0;
            fill_go_o  <= 1'b0;
            rd_valid_o <= 1'b0;
            busy_o     <= 1'b1;  // stays up until init is over
        end else begin
            req_o      <= pend_nxt;
            fill_go_o  <= fill_take;
            rd_valid_o <= done_i && req_bus_o.rd;
            // covers the gap before the engine raises its own busy
            busy_o <= pend_nxt || fill_take || fill_go_o || fill_busy_i || !init_done_i;
        end
    end

    always_ff @(posedge pclk) begin
        if (we_take || rd_take) begin
            req_bus_o <= '{rd: rd_take, rs: host_rs_i, data: host_data_i};
        end
        if (fill_take) fill_job_o <= fill_job_i;
        if (done_i && req_bus_o.rd) rd_data_o <= rd_word_i;  // captured with done
    end

endmodule

// File: lcd_bus_mux.sv
// fixed priority panel bus arbiter: init, then host, then fill
`timescale 1ns/1ps

module lcd_bus_mux (
    input  logic              pclk,
    input  logic              rst_n,
    input  logic              init_req_i,
    input  lcd_pkg::bus_req_t init_bus_i,
    input  logic              host_req_i,
    input  lcd_pkg::bus_req_t host_bus_i,
    input  logic              fill_req_i,
    input  lcd_pkg::bus_req_t fill_bus_i,
    input  logic              init_done_i,
    output logic              init_done_o,
    output logic              host_done_o,
    output logic              fill_done_o,
    output logic              start_o,
    output lcd_pkg::bus_req_t bus_o,
    input  logic              done_i
);
    import lcd_pkg::*;

    typedef enum logic [1:0] {OWN_NONE, OWN_INIT, OWN_HOST, OWN_FILL} owner_e;

    owner_e own_q;

    // grant locked until done, re-arbitrate the cycle after
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            own_q   <= OWN_NONE;
            start_o <= 1'b0;
        end else begin
            start_o <= 1'b0;
            if (own_q == OWN_NONE) begin
                if (init_req_i) begin
                    own_q   <= OWN_INIT;
                    start_o <= 1'b1;
                end else if (init_done_i && host_req_i) begin
                    own_q   <= OWN_HOST;
                    start_o <= 1'b1;
                end else if (init_done_i && fill_req_i) begin
                    own_q   <= OWN_FILL;
                    start_o <= 1'b1;
                end
            end else if (done_i) begin
                own_q <= OWN_NONE;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (own_q == OWN_NONE) begin
            bus_o <= init_req_i ? init_bus_i : (host_req_i ? host_bus_i : fill_bus_i);
        end
    end

    assign init_done_o = done_i && (own_q == OWN_INIT);
    assign host_done_o = done_i && (own_q == OWN_HOST);
    assign fill_done_o = done_i && (own_q == OWN_FILL);

endmodule

// File: lcd_bus_if.sv
// 8080 panel bus cycles: cs, rs, wr, rd, data enable, read sampling and backlight
`timescale 1ns/1ps

module lcd_bus_if (
    input  logic              pclk,
    input  logic              rst_n,
    input  logic              start_i,
    input  lcd_pkg::bus_req_t bus_i,
    input  logic              init_done_i,
    output logic              done_o,
    output logic [15:0]       rd_word_o,
    output logic              lcd_cs_o,
    output logic              lcd_rs_o,
    output logic              lcd_wr_o,
    output logic              lcd_rd_o,
    output logic [15:0]       lcd_data_o,
    output logic              lcd_data_oe_o,
    input  logic [15:0]       lcd_data_i,
    output logic              lcd_bl_o
);
    import lcd_pkg::*;

    bus_req_t        req_q;
    logic            active_q;
    logic [PH_W-1:0] ph_q;
    logic [15:0]     rd_word_q;
    logic            last_ph;

    // write is 4 phases, read is 12
    assign last_ph = req_q.rd ? (ph_q == RD_LAST) : (ph_q == WR_LAST);

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            ph_q     <= '0;
        end else if (start_i) begin
            active_q <= 1'b1;
            ph_q     <= '0;
        end else if (active_q) begin
            if (last_ph) begin
                active_q <= 1'b0;
                ph_q     <= '0;
            end else begin
                ph_q <= ph_q + 1'b1;
            end
        end
    end

    // operation and sampled read word
    always_ff @(posedge pclk) begin
        if (start_i) begin
            req_q <= bus_i;
        end
        if (active_q && req_q.rd && ph_q == RD_SMP) begin
            rd_word_q <= lcd_data_i;  // last rd low cycle
        end
    end

    assign done_o    = active_q && last_ph;
    assign rd_word_o = rd_word_q;

    // strobes low active, all idle high
    assign lcd_cs_o = !active_q;
    assign lcd_rs_o = !active_q || req_q.rs;
    assign lcd_wr_o = !(active_q && !req_q.rd && ph_q < WR_LOW_END);  // rises mid cycle
    assign lcd_rd_o = !(active_q && req_q.rd && ph_q < RD_LOW_END);

    // drive the bus only on writes
    assign lcd_data_o    = req_q.data;
    assign lcd_data_oe_o = active_q && !req_q.rd;

    assign lcd_bl_o = init_done_i;  // backlight on once the panel is set up

endmodule

// File: lcd_top.sv
// TFT panel controller top: init sequencer, host port, fill engine, bus mux, bus interface
`timescale 1ns/1ps

module lcd_top (
    input  logic               pclk,
    input  logic               rst_n,
    input  logic               host_we_i,
    input  logic               host_rs_i,
    input  logic [15:0]        host_data_i,
    input  logic               host_rd_i,
    input  logic               fill_start_i,
    input  lcd_pkg::fill_req_t fill_job_i,
    output logic [15:0]        rd_data_o,
    output logic               rd_valid_o,
    output logic               busy_o,
    output logic               lcd_rst_o,
    output logic               lcd_cs_o,
    output logic               lcd_rs_o,
    output logic               lcd_wr_o,
    output logic               lcd_rd_o,
    output logic [15:0]        lcd_data_o,
    output logic               lcd_data_oe_o,
    input  logic [15:0]        lcd_data_i,
    output logic               lcd_bl_o
);
    import lcd_pkg::*;

    bus_req_t    init_bus, host_bus, fill_bus, mux_bus;
    fill_req_t   fill_job;
    logic        init_req, host_req, fill_req;
    logic        init_done_p, host_done_p, fill_done_p;  // done pulses per source
    logic        init_done, fill_go, fill_busy;
    logic        start, done;
    logic [15:0] rd_word;

    lcd_init_seq u_init (
        .pclk(pclk), .rst_n(rst_n), .req_o(init_req), .req_bus_o(init_bus),
        .done_i(init_done_p), .lcd_rst_o(lcd_rst_o), .init_done_o(init_done)
    );

    lcd_host_port u_host (
        .pclk(pclk), .rst_n(rst_n), .host_we_i(host_we_i), .host_rs_i(host_rs_i),
        .host_data_i(host_data_i), .host_rd_i(host_rd_i), .fill_start_i(fill_start_i),
        .fill_job_i(fill_job_i), .init_done_i(init_done), .fill_busy_i(fill_busy),
        .req_o(host_req), .req_bus_o(host_bus), .done_i(host_done_p), .rd_word_i(rd_word),
        .fill_go_o(fill_go), .fill_job_o(fill_job), .busy_o(busy_o),
        .rd_data_o(rd_data_o), .rd_valid_o(rd_valid_o)
    );

    lcd_fill_engine u_fill (
        .pclk(pclk), .rst_n(rst_n), .start_i(fill_go), .job_i(fill_job),
        .req_o(fill_req), .req_bus_o(fill_bus), .done_i(fill_done_p), .busy_o(fill_busy)
    );

    lcd_bus_mux u_mux (
        .pclk(pclk), .rst_n(rst_n), .init_req_i(init_req), .init_bus_i(init_bus),
        .host_req_i(host_req), .host_bus_i(host_bus), .fill_req_i(fill_req),
        .fill_bus_i(fill_bus), .init_done_i(init_done), .init_done_o(init_done_p),
        .host_done_o(host_done_p), .fill_done_o(fill_done_p), .start_o(start),
        .bus_o(mux_bus), .done_i(done)
    );

    lcd_bus_if u_bus_if (
        .pclk(pclk), .rst_n(rst_n), .start_i(start), .bus_i(mux_bus),
        .init_done_i(init_done), .done_o(done), .rd_word_o(rd_word),
        .lcd_cs_o(lcd_cs_o), .lcd_rs_o(lcd_rs_o), .lcd_wr_o(lcd_wr_o), .lcd_rd_o(lcd_rd_o),
        .lcd_data_o(lcd_data_o), .lcd_data_oe_o(lcd_data_oe_o), .lcd_data_i(lcd_data_i),
        .lcd_bl_o(lcd_bl_o)
    );

endmodule

// File: tb_lcd_panel.sv
// panel model: bus resolution, write log and fixed ID word on reads
`timescale 1ns/1ps

module tb_lcd_panel (
    input  logic        cs_n_i,
    input  logic        rs_i,
    input  logic        wr_n_i,
    input  logic        rd_n_i,
    input  logic [15:0] data_i,
    input  logic        data_oe_i,
    output logic [15:0] data_o
);
    localparam int          LOG_MAX = 256;
    localparam logic [15:0] ID_WORD = 16'h9341;

    logic [15:0] bus;
    logic        log_rs   [0:LOG_MAX-1];
    logic [15:0] log_data [0:LOG_MAX-1];
    int          log_cnt = 0;

    // controller drives on writes, panel answers while rd is low
    assign bus    = data_oe_i ? data_i : ((!rd_n_i && !cs_n_i) ? ID_WORD : 16'h0000);
    assign data_o = bus;

    // panel latches on the rising wr edge
    always @(posedge wr_n_i) begin
        if (!cs_n_i && log_cnt < LOG_MAX) begin
            log_rs[log_cnt]   <= rs_i;
            log_data[log_cnt] <= bus;
            log_cnt           <= log_cnt + 1;
        end
    end

endmodule

// File: tb_lcd_properties.sv
// concurrent assertions on the 8080 strobe timing and the data enable
`timescale 1ns/1ps

module tb_lcd_properties (
    input logic pclk,
    input logic rst_n,
    input logic cs_n_i,
    input logic wr_n_i,
    input logic rd_n_i,
    input logic data_oe_i
);
    import lcd_pkg::*;

    int unsigned fail_cnt = 0;  // failed assertions so far

    wr_low_time: assert property (@(posedge pclk) disable iff (!rst_n)
        $fell(wr_n_i) |-> ##WR_LOW_CYC $rose(wr_n_i))
        else begin
            $error("wr low time differs from WR_LOW_CYC");
            fail_cnt++;
        end

    wr_rd_apart: assert property (@(posedge pclk) disable iff (!rst_n)
        !(!wr_n_i && !rd_n_i))
        else begin
            $error("wr and rd low together");
            fail_cnt++;
        end

    // controller may drive only inside a write cycle
    oe_in_write: assert property (@(posedge pclk) disable iff (!rst_n)
        data_oe_i |-> (!cs_n_i && rd_n_i))
        else begin
            $error("data enable outside a write cycle");
            fail_cnt++;
        end

endmodule

bind lcd_bus_if tb_lcd_properties bus_props (
    .pclk(pclk), .rst_n(rst_n), .cs_n_i(lcd_cs_o), .wr_n_i(lcd_wr_o),
    .rd_n_i(lcd_rd_o), .data_oe_i(lcd_data_oe_o)
);

// File: tb_lcd_top.sv
// testbench top: clock, reset, watchdog, LFSR, value check and directed tests
`timescale 1ns/1ps

module tb_lcd_top;
    import lcd_pkg::*;

    localparam int CLK_PER  = 20;
    localparam int RST_LEN  = 10;
    localparam int N_WR     = 8;
    localparam int MAX_PIX  = 16;  // fills are at most 4 x 4
    localparam int OP_CYC   = 16;  // one bus op with arbitration, read included
    localparam int WAIT_MAX = (11 + MAX_PIX) * OP_CYC;
    localparam int WD_CYC   = 2 * (RST_LEN + RST_CYC
                              + (INIT_LEN + N_WR + 1 + 2 * (11 + MAX_PIX)) * OP_CYC);

    logic        pclk, rst_n;
    logic        host_we, host_rs, host_rd, fill_start;
    logic [15:0] host_data, rd_data, lcd_data_o, lcd_data_i;
    fill_req_t   fill_job;
    logic        rd_valid, busy, lcd_rst, lcd_cs, lcd_rs, lcd_wr, lcd_rd, lcd_oe, lcd_bl;
    logic [31:0] lfsr;
    int          errs, checks, tests, failed;
    int          rd_pulses;

    // expected init list, rs above the word
    logic [16:0] init_tab [0:INIT_LEN-1] = '{17'h00011, 17'h0003A, 17'h10055,
                                            17'h00036, 17'h10000, 17'h00029};

    lcd_top dut (
        .pclk(pclk), .rst_n(rst_n), .host_we_i(host_we), .host_rs_i(host_rs),
        .host_data_i(host_data), .host_rd_i(host_rd), .fill_start_i(fill_start),
        .fill_job_i(fill_job), .rd_data_o(rd_data), .rd_valid_o(rd_valid), .busy_o(busy),
        .lcd_rst_o(lcd_rst), .lcd_cs_o(lcd_cs), .lcd_rs_o(lcd_rs), .lcd_wr_o(lcd_wr),
        .lcd_rd_o(lcd_rd), .lcd_data_o(lcd_data_o), .lcd_data_oe_o(lcd_oe),
        .lcd_data_i(lcd_data_i), .lcd_bl_o(lcd_bl)
    );

    tb_lcd_panel panel (
        .cs_n_i(lcd_cs), .rs_i(lcd_rs), .wr_n_i(lcd_wr), .rd_n_i(lcd_rd),
        .data_i(lcd_data_o), .data_oe_i(lcd_oe), .data_o(lcd_data_i)
    );

    initial begin
        pclk = 1'b0;
        forever #(CLK_PER / 2) pclk = ~pclk;
    end

    initial begin
        #(WD_CYC * CLK_PER);
        $display("watchdog expired after %0d cycles, run aborted", WD_CYC);
        $display(">>> FAIL");
        $finish;
    end

    // read completions seen by the host
    always @(negedge pclk) begin
        if (rd_valid) rd_pulses++;
    end

    // galois lfsr, one step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_log(input int idx, input logic rs, input logic [15:0] data);
        check_value($sformatf("panel rs[%0d]", idx), 16'(panel.log_rs[idx]), 16'(rs));
        check_value($sformatf("panel data[%0d]", idx), panel.log_data[idx], data);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errs == errs_before) begin
            $display("test %-12s ok", name);
        end else begin
            failed++;
            $display("test %-12s failed with %0d errors", name, errs - errs_before);
        end
    endtask

    // busy sampled on the falling edge
    task automatic wait_idle(input string what);
        int n;
        n = 0;
        @(negedge pclk);
        while (busy && n < WAIT_MAX) begin
            @(negedge pclk);
            n++;
        end
        if (busy) begin
            errs++;
            $display("busy never fell during %s", what);
        end
    endtask

    // one-cycle strobe, driven just after the rising edge
    task automatic drive_strobe(input logic we, input logic rd, input logic fs,
                                input logic rs, input logic [15:0] data,
                                input fill_req_t job);
        @(posedge pclk);
        #2;
        host_we    = we;
        host_rd    = rd;
        fill_start = fs;
        host_rs    = rs;
        host_data  = data;
        fill_job   = job;
        @(posedge pclk);
        #2;
        host_we    = 1'b0;
        host_rd    = 1'b0;
        fill_start = 1'b0;
    endtask

    task automatic make_job(output fill_req_t job, output int npix);
        logic [15:0] w, h;
        job.x0    = rand_bits(10);
        job.y0    = rand_bits(10);
        w         = rand_bits(2) + 16'd1;
        h         = rand_bits(2) + 16'd1;
        job.x1    = job.x0 + w - 16'd1;
        job.y1    = job.y0 + h - 16'd1;
        job.color = rand_bits(16);
        npix      = int'(w * h);
    endtask

    // window commands, byte parameters, RAMWR, then the colour stream
    task automatic check_fill(input int base, input fill_req_t job, input int npix);
        logic [15:0] coord [0:3];
        int          pos;
        coord = '{job.x0, job.x1, job.y0, job.y1};
        check_value("fill log count", 16'(panel.log_cnt - base), 16'(11 + npix));
        check_log(base, 1'b0, CMD_CASET);
        check_log(base + 5, 1'b0, CMD_PASET);
        check_log(base + 10, 1'b0, CMD_RAMWR);
        for (int k = 0; k < 4; k++) begin
            pos = base + 1 + 2 * k + k / 2;
            check_log(pos, 1'b1, {8'h00, coord[k][15:8]});
            check_log(pos + 1, 1'b1, {8'h00, coord[k][7:0]});
        end
        for (int i = 0; i < npix; i++) check_log(base + 11 + i, 1'b1, job.color);
    endtask

    task automatic test_reset_init();
        int e0, low;
        e0  = errs;
        low = 0;
        check_value("lcd_rst_o", 16'(lcd_rst), 16'h0);
        check_value("lcd_cs_o", 16'(lcd_cs), 16'h1);
        check_value("lcd_wr_o", 16'(lcd_wr), 16'h1);
        check_value("lcd_rd_o", 16'(lcd_rd), 16'h1);
        check_value("lcd_data_oe_o", 16'(lcd_oe), 16'h0);
        check_value("lcd_bl_o", 16'(lcd_bl), 16'h0);
        check_value("busy_o", 16'(busy), 16'h1);
        check_value("rd_valid_o", 16'(rd_valid), 16'h0);
        while (!lcd_rst && low < 4 * RST_CYC) begin
            @(negedge pclk);
            if (!lcd_rst) low++;
        end
        check_value("lcd_rst_o low cycles", 16'(low), 16'(RST_CYC));
        wait_idle("init");
        check_value("init log count", 16'(panel.log_cnt), 16'(INIT_LEN));
        for (int i = 0; i < INIT_LEN; i++) check_log(i, init_tab[i][16], init_tab[i][15:0]);
        check_value("lcd_bl_o", 16'(lcd_bl), 16'h1);
        report_test("reset_init", e0);
    endtask

    task automatic test_host_writes();
        int          e0, base;
        logic        rs;
        logic [15:0] d;
        logic [16:0] exp [0:N_WR-1];
        e0   = errs;
        base = panel.log_cnt;
        for (int i = 0; i < N_WR; i++) begin
            d      = rand_bits(1);
            rs     = d[0];
            d      = rand_bits(16);
            exp[i] = {rs, d};
            drive_strobe(1'b1, 1'b0, 1'b0, rs, d, fill_job);
            wait_idle("host write");
        end
        check_value("write log count", 16'(panel.log_cnt - base), 16'(N_WR));
        for (int i = 0; i < N_WR; i++) check_log(base + i, exp[i][16], exp[i][15:0]);
        report_test("host_writes", e0);
    endtask

    task automatic test_read();
        int e0, n;
        e0 = errs;
        n  = 0;
        drive_strobe(1'b0, 1'b1, 1'b0, 1'b0, 16'h0000, fill_job);
        while (!rd_valid && n < WAIT_MAX) begin
            @(negedge pclk);
            n++;
        end
        if (!rd_valid) begin
            errs++;
            $display("rd_valid_o never pulsed after a read strobe");
        end else begin
            check_value("rd_data_o", rd_data, 16'h9341);
            check_value("busy_o", 16'(busy), 16'h0);  // falls with rd_valid
        end
        @(negedge pclk);
        check_value("rd_valid_o", 16'(rd_valid), 16'h0);
        report_test("host_read", e0);
    endtask

    task automatic test_fill();
        int        e0, base, npix;
        fill_req_t job;
        e0 = errs;
        make_job(job, npix);
        base = panel.log_cnt;
        drive_strobe(1'b0, 1'b0, 1'b1, 1'b0, 16'h0000, job);
        wait_idle("fill");
        check_fill(base, job, npix);
        report_test("fill", e0);
    endtask

    // strobes during a fill must leave no trace on the bus
    task automatic test_busy_strobes();
        int        e0, base, npix, rd0;
        fill_req_t job, other;
        e0 = errs;
        make_job(job, npix);
        other       = job;
        other.color = ~job.color;
        base        = panel.log_cnt;
        rd0         = rd_pulses;
        drive_strobe(1'b0, 1'b0, 1'b1, 1'b0, 16'h0000, job);
        check_value("busy_o", 16'(busy), 16'h1);
        drive_strobe(1'b1, 1'b0, 1'b0, 1'b1, rand_bits(16), other);
        check_value("busy_o", 16'(busy), 16'h1);
        drive_strobe(1'b0, 1'b1, 1'b0, 1'b0, 16'h0000, other);
        check_value("busy_o", 16'(busy), 16'h1);
        drive_strobe(1'b0, 1'b0, 1'b1, 1'b0, 16'h0000, other);
        wait_idle("fill with strobes");
        check_fill(base, job, npix);
        check_value("rd_valid_o pulses", 16'(rd_pulses - rd0), 16'h0);  // read was dropped
        report_test("busy_strobes", e0);
    endtask

    initial begin
        lfsr       = 32'h4340_7803;
        errs       = 0;
        checks     = 0;
        tests      = 0;
        failed     = 0;
        rd_pulses  = 0;
        rst_n      = 1'b0;
        host_we    = 1'b0;
        host_rs    = 1'b0;
        host_data  = 16'h0000;
        host_rd    = 1'b0;
        fill_start = 1'b0;
        fill_job   = '0;
        repeat (RST_LEN) @(posedge pclk);
        #2;
        rst_n = 1'b1;
        test_reset_init();
        test_host_writes();
        test_read();
        test_fill();
        test_busy_strobes();
        if (dut.u_bus_if.bus_props.fail_cnt != 0) begin
            errs++;
            $display("bus timing assertions failed %0d times", dut.u_bus_if.bus_props.fail_cnt);
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errs);
        if (errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
lcd_pkg.sv
lcd_init_seq.sv
lcd_fill_engine.sv
lcd_host_port.sv
lcd_bus_mux.sv
lcd_bus_if.sv
lcd_top.sv
tb_lcd_panel.sv
tb_lcd_properties.sv
tb_lcd_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lcd_top
RTL_TOP   ?= lcd_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	@$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q ">>> FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(filter-out tb_%,$(SOURCES))

clean:
	rm -rf $(OBJ_DIR) $(LOG)
